//--- ddr3_lite_top.f
+incdir+include
hw/ddr3_cmd_pkg.sv
hw/ddr3_bus_pkg.sv
hw/ddr3_req_ctrl.sv
hw/ddr3_timer.sv
hw/ddr3_fsm.sv
hw/ddr3_dfi_path.sv
hw/ddr3_lite_top.sv
bench/ddr3_clock_gen.sv
bench/ddr3_dfi_model.sv
bench/ddr3_lite_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the DDR3 controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f ddr3_lite_top.f \
  --top-module ddr3_lite_tb \
  -o ddr3_lite_sim

./obj_dir/ddr3_lite_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
  exit 0
else
  exit 1
fi

//--- bench/ddr3_lite_tb.sv
`timescale 1ns/1ps
`include "ddr3_lite_defs.svh"

module ddr3_lite_tb import ddr3_cmd_pkg::*, ddr3_bus_pkg::*;;

  localparam int INIT = `DDR_INIT_CYCLES;
  // Init, three refresh intervals and about 60 accesses of up to 40 cycles
  localparam int TIMEOUT_CYCLES = `DDR_INIT_CYCLES + 3 * `DDR_TREFI + 60 * 40;

  logic clock;
  logic reset;
  logic axi_awvalid_i, axi_awready_o, axi_wvalid_i, axi_wready_o;
  logic axi_bvalid_o, axi_bready_i, axi_arvalid_i, axi_arready_o;
  logic axi_rvalid_o, axi_rready_i;
  mem_addr_t axi_awaddr_i, axi_araddr_i;
  id_t axi_awid_i, axi_arid_i, axi_bid_o, axi_rid_o;
  mask_t axi_wstrb_i;
  data_t axi_wdata_i, axi_rdata_o;
  logic dfi_rst_no, dfi_cke_o, dfi_cs_no, dfi_ras_no, dfi_cas_no, dfi_we_no, dfi_odt_o;
  bank_t dfi_bank_o;
  row_t dfi_addr_o;
  logic dfi_wren_o, dfi_rden_o, dfi_rvld_i;
  mask_t dfi_mask_o;
  data_t dfi_data_o, dfi_data_i;

  int seed = 38233;
  int tick, cyc, err_count, test_errs, tests_run, tests_failed;
  int since_act, since_pre, since_wr, since_ref, ref_count;
  logic cmd_seen, stall_mode;
  logic [3:0] stall_bits;
  bank_t act_bank;
  string test_name;
  id_t exp_bid [0:255];
  id_t exp_rid [0:255];
  data_t exp_rdata [0:255];
  logic [7:0] b_head, b_tail, r_head, r_tail;
  data_t sb [0:63];  // Expected memory per address slot
  mem_addr_t addr_pool [0:63];
  logic [3:0] cmd_bits;
  id_t head_bid, head_rid;
  data_t head_rdata;

  ddr3_clock_gen u_clock (.clock_o(clock), .reset_o(reset));

  ddr3_lite_top UUT (.*);

  ddr3_dfi_model u_dram (
    .clock (clock), .reset (reset), .cs_ni (dfi_cs_no), .ras_ni (dfi_ras_no),
    .cas_ni (dfi_cas_no), .we_ni (dfi_we_no), .bank_i (dfi_bank_o), .addr_i (dfi_addr_o),
    .wren_i (dfi_wren_o), .mask_i (dfi_mask_o), .data_i (dfi_data_o),
    .rden_i (dfi_rden_o), .rvld_o (dfi_rvld_i), .data_o (dfi_data_i)
  );

  assign cmd_bits   = {dfi_cs_no, dfi_ras_no, dfi_cas_no, dfi_we_no};
  assign head_bid   = exp_bid[b_head];
  assign head_rid   = exp_rid[r_head];
  assign head_rdata = exp_rdata[r_head];

  // Spacing counters, set to 1 on the command
  always @(posedge clock) begin
    if (reset) begin
      cyc <= 0;
      since_act <= 100;
      since_pre <= 100;
      since_wr <= 100;
      since_ref <= 0;
      ref_count <= 0;
      cmd_seen <= 1'b0;
      b_head <= '0;
      r_head <= '0;
    end else begin
      cyc <= cyc + 1;
      since_act <= (cmd_bits == CMD_ACT) ? 1 : since_act + 1;
      since_pre <= (cmd_bits == CMD_PRE) ? 1 : since_pre + 1;
      since_wr <= (cmd_bits == CMD_WR) ? 1 : since_wr + 1;
      since_ref <= (cmd_bits == CMD_REF) ? 1 : since_ref + 1;
      if (cmd_bits == CMD_REF) ref_count <= ref_count + 1;
      if (cmd_bits == CMD_ACT) act_bank <= dfi_bank_o;
      if (!dfi_cs_no) cmd_seen <= 1'b1;
      if (axi_bvalid_o && axi_bready_i) b_head <= b_head + 1'b1;
      if (axi_rvalid_o && axi_rready_i) r_head <= r_head + 1'b1;
    end
  end

  always @(posedge clock) begin
    tick <= tick + 1;
    if (tick >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the run did not finish", tick);
      $display("Some tests failed");
      $finish;
    end
  end

  // Stall pattern drawn on the rising edge while stall_mode is on
  always @(posedge clock) begin
    stall_bits <= stall_mode ? 4'($random(seed)) : 4'b0000;
  end

  always @(negedge clock) begin
    axi_rready_i = (stall_bits[1:0] == 2'b00);
    axi_bready_i = (stall_bits[3:2] == 2'b00);
  end

  task automatic note_failure(input string what);
    err_count++;
    $display("%s: %s", test_name, what);
  endtask

  a_init_quiet: assert property (@(posedge clock) disable iff (reset)
    cyc < INIT |-> !dfi_cke_o && dfi_cs_no && !axi_awready_o && !axi_wready_o && !axi_arready_o)
    else note_failure("CKE, a command or a ready came up during init");
  a_cke_up: assert property (@(posedge clock) disable iff (reset)
    cyc == INIT + 1 |-> dfi_cke_o)
    else note_failure("CKE did not rise after the init delay");
  a_rst_out: assert property (@(posedge clock) disable iff (reset)
    dfi_rst_no == (cyc > 0))
    else note_failure("DRAM reset pin not released right after reset");
  a_mrs_first: assert property (@(posedge clock) disable iff (reset)
    !cmd_seen && !dfi_cs_no |-> cmd_bits == CMD_MRS)
    else note_failure("first DRAM command was not MRS");
  a_rw_trcd: assert property (@(posedge clock) disable iff (reset)
    cmd_bits == CMD_RD || cmd_bits == CMD_WR |-> since_act == `DDR_TRCD && dfi_bank_o == act_bank)
    else note_failure("RD or WR not tRCD after ACT to its bank");
  a_act_trp: assert property (@(posedge clock) disable iff (reset)
    cmd_bits == CMD_ACT |-> since_pre >= `DDR_TRP)
    else note_failure("ACT came too soon after PRE");
  a_wren_cwl: assert property (@(posedge clock) disable iff (reset)
    dfi_wren_o == (since_wr == `DDR_CWL))
    else note_failure("write enable not CWL cycles after WR");
  a_odt_write: assert property (@(posedge clock) disable iff (reset)
    (cmd_bits == CMD_WR || dfi_wren_o |-> dfi_odt_o) and
    (cmd_bits == CMD_RD || cmd_bits == CMD_ACT |-> !dfi_odt_o))
    else note_failure("ODT does not follow write activity");
  a_ref_interval: assert property (@(posedge clock) disable iff (reset)
    since_ref <= `DDR_TREFI + 40)
    else note_failure("refresh interval exceeded");
  a_trfc: assert property (@(posedge clock) disable iff (reset)
    !dfi_cs_no && cmd_bits != CMD_REF && ref_count > 0 |-> since_ref >= `DDR_TRFC)
    else note_failure("command issued within tRFC of REF");
  a_bid: assert property (@(posedge clock) disable iff (reset)
    axi_bvalid_o && axi_bready_i |-> axi_bid_o == head_bid)
    else begin
      err_count++;
      $display("MISMATCH %s: bid expected %h actual %h", test_name, $sampled(head_bid),
               $sampled(axi_bid_o));
    end
  a_rid: assert property (@(posedge clock) disable iff (reset)
    axi_rvalid_o && axi_rready_i |-> axi_rid_o == head_rid)
    else begin
      err_count++;
      $display("MISMATCH %s: rid expected %h actual %h", test_name, $sampled(head_rid),
               $sampled(axi_rid_o));
    end
  a_rdata: assert property (@(posedge clock) disable iff (reset)
    axi_rvalid_o && axi_rready_i |-> axi_rdata_o == head_rdata)
    else begin
      err_count++;
      $display("MISMATCH %s: rdata expected %h actual %h", test_name, $sampled(head_rdata),
               $sampled(axi_rdata_o));
    end
  a_no_extra: assert property (@(posedge clock) disable iff (reset)
    (axi_bvalid_o && axi_bready_i |-> b_head != b_tail) and
    (axi_rvalid_o && axi_rready_i |-> r_head != r_tail))
    else note_failure("response with nothing outstanding");
  a_b_stable: assert property (@(posedge clock) disable iff (reset)
    axi_bvalid_o && !axi_bready_i |=> axi_bvalid_o && $stable(axi_bid_o))
    else note_failure("B changed before its handshake");
  a_r_stable: assert property (@(posedge clock) disable iff (reset)
    axi_rvalid_o && !axi_rready_i |=> axi_rvalid_o && $stable(axi_rid_o) && $stable(axi_rdata_o))
    else note_failure("R changed before its handshake");

  function automatic data_t merge_strobed(data_t old_word, data_t new_word, mask_t strb);
    data_t result;
    result = old_word;
    for (int b = 0; b < `DDR_MASK_BITS; b++) begin
      if (strb[b]) result[8*b +: 8] = new_word[8*b +: 8];
    end
    return result;
  endfunction

  task automatic write_word(input int idx, input data_t data, input mask_t strb, input id_t id);
    logic aw_fire;
    logic w_fire;
    logic aw_done;
    logic w_done;
    aw_done = 1'b0;
    w_done = 1'b0;
    sb[idx] = merge_strobed(sb[idx], data, strb);
    exp_bid[b_tail] = id;
    b_tail = b_tail + 1'b1;
    @(negedge clock);
    axi_awvalid_i = 1'b1;
    axi_awaddr_i = addr_pool[idx];
    axi_awid_i = id;
    axi_wvalid_i = 1'b1;
    axi_wdata_i = data;
    axi_wstrb_i = strb;
    while (!(aw_done && w_done)) begin
      aw_fire = axi_awvalid_i && axi_awready_o;  // Ready is registered, stable here
      w_fire = axi_wvalid_i && axi_wready_o;
      @(negedge clock);
      if (aw_fire) begin
        aw_done = 1'b1;
        axi_awvalid_i = 1'b0;
      end
      if (w_fire) begin
        w_done = 1'b1;
        axi_wvalid_i = 1'b0;
      end
    end
  endtask

  task automatic read_word(input int idx, input id_t id);
    logic ar_fire;
    exp_rid[r_tail] = id;
    exp_rdata[r_tail] = sb[idx];
    r_tail = r_tail + 1'b1;
    @(negedge clock);
    axi_arvalid_i = 1'b1;
    axi_araddr_i = addr_pool[idx];
    axi_arid_i = id;
    ar_fire = 1'b0;
    while (!ar_fire) begin
      ar_fire = axi_arvalid_i && axi_arready_o;
      @(negedge clock);
    end
    axi_arvalid_i = 1'b0;
  endtask

  task automatic wait_idle();
    while (b_head != b_tail || r_head != r_tail) @(negedge clock);
  endtask

  task automatic end_test();
    tests_run++;
    if (err_count != test_errs) tests_failed++;
    $display("Test %s finished with %0d errors", test_name, err_count - test_errs);
    test_errs = err_count;
  endtask

  initial begin
    int idx;
    int rd_idx;
    int ref_start;
    data_t data;
    mask_t strb;
    {axi_awvalid_i, axi_wvalid_i, axi_arvalid_i} = '0;
    {axi_awaddr_i, axi_araddr_i, axi_awid_i, axi_arid_i} = '0;
    axi_wstrb_i = '0;
    axi_wdata_i = '0;
    axi_rready_i = 1'b1;
    axi_bready_i = 1'b1;
    {tick, err_count, test_errs, tests_run, tests_failed} = '0;
    {b_tail, r_tail} = '0;
    stall_mode = 1'b0;
    for (int i = 0; i < 64; i++) begin
      sb[i] = '0;
      addr_pool[i] = {bank_t'($random(seed)), row_t'($random(seed)), col_t'(i)};  // Unique column
    end

    test_name = "init";
    @(negedge clock);
    while (!axi_awready_o) @(negedge clock);
    end_test();

    test_name = "write_read";
    for (int i = 0; i < 20; i++) begin
      write_word(i, data_t'($random(seed)), mask_t'($random(seed)), id_t'(i));
      wait_idle();
      repeat (2) begin
        idx = {$random(seed)} % (i + 1);
        read_word(idx, id_t'($random(seed)));
        wait_idle();
      end
    end
    end_test();

    test_name = "back_pressure";
    stall_mode = 1'b1;
    for (int i = 0; i < 8; i++) begin
      idx = {$random(seed)} % 20;
      write_word(idx, data_t'($random(seed)), mask_t'($random(seed)), id_t'(i));
      wait_idle();
      read_word(idx, id_t'(15 - i));
      wait_idle();
    end
    stall_mode = 1'b0;
    end_test();

    test_name = "interleave";
    for (int i = 0; i < 4; i++) begin
      rd_idx = {$random(seed)} % 20;
      data = data_t'($random(seed));
      strb = mask_t'($random(seed));
      fork
        write_word(20 + i, data, strb, id_t'(2 * i));
        read_word(rd_idx, id_t'(2 * i + 1));
      join
      wait_idle();
    end
    end_test();

    // Keep reading until two more refreshes have gone by
    test_name = "refresh";
    ref_start = ref_count;
    while (ref_count < ref_start + 2) begin
      read_word({$random(seed)} % 24, id_t'($random(seed)));
      wait_idle();
    end
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- bench/ddr3_dfi_model.sv
`timescale 1ns/1ps
`include "ddr3_lite_defs.svh"

module ddr3_dfi_model import ddr3_cmd_pkg::*, ddr3_bus_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  cs_ni,
  input  logic  ras_ni,
  input  logic  cas_ni,
  input  logic  we_ni,
  input  bank_t bank_i,
  input  row_t  addr_i,
  input  logic  wren_i,
  input  mask_t mask_i,
  input  data_t data_i,
  input  logic  rden_i,
  output logic  rvld_o,
  output data_t data_o
);

  data_t     mem [mem_addr_t];  // Sparse storage, unwritten reads as zero
  row_t      open_row [0:(1<<`DDR_BANK_BITS)-1];
  mem_addr_t wr_addr;
  mem_addr_t rd_addr;
  logic      rden_d;
  logic [3:0] cmd_bits;

  assign cmd_bits = {cs_ni, ras_ni, cas_ni, we_ni};

  always @(posedge clock) begin
    data_t word;
    word = '0;
    if (reset) begin
      rden_d <= 1'b0;
      rvld_o <= 1'b0;
    end else begin
      if (cmd_bits == CMD_ACT) open_row[bank_i] <= addr_i;
      if (cmd_bits == CMD_WR) wr_addr <= {bank_i, open_row[bank_i], addr_i[`DDR_COL_BITS-1:0]};
      if (cmd_bits == CMD_RD) rd_addr <= {bank_i, open_row[bank_i], addr_i[`DDR_COL_BITS-1:0]};
      if (wren_i) begin
        if (mem.exists(wr_addr)) word = mem[wr_addr];
        for (int b = 0; b < `DDR_MASK_BITS; b++) begin
          if (!mask_i[b]) word[8*b +: 8] = data_i[8*b +: 8];  // DM low writes the byte
        end
        mem[wr_addr] = word;
      end
      // Read data two cycles after the read enable
      rden_d <= rden_i;
      rvld_o <= rden_d;
      if (rden_d) data_o <= mem.exists(rd_addr) ? mem[rd_addr] : '0;
    end
  end

endmodule

//--- bench/ddr3_clock_gen.sv
`timescale 1ns/1ps

module ddr3_clock_gen (
  output logic clock_o,
  output logic reset_o
);

  initial begin
    clock_o = 1'b0;
    reset_o = 1'b1;
    repeat (3) @(posedge clock_o);
    @(negedge clock_o);
    reset_o = 1'b0;  // Released away from the active edge
  end

  always #2 clock_o = ~clock_o;  // 4 ns period

endmodule

//--- hw/ddr3_lite_top.sv
`timescale 1ns/1ps
`include "ddr3_lite_defs.svh"

module ddr3_lite_top import ddr3_cmd_pkg::*, ddr3_bus_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      axi_awvalid_i,
  output logic      axi_awready_o,
  input  mem_addr_t axi_awaddr_i,
  input  id_t       axi_awid_i,
  input  logic      axi_wvalid_i,
  output logic      axi_wready_o,
  input  mask_t     axi_wstrb_i,
  input  data_t     axi_wdata_i,
  output logic      axi_bvalid_o,
  input  logic      axi_bready_i,
  output id_t       axi_bid_o,
  input  logic      axi_arvalid_i,
  output logic      axi_arready_o,
  input  mem_addr_t axi_araddr_i,
  input  id_t       axi_arid_i,
  output logic      axi_rvalid_o,
  input  logic      axi_rready_i,
  output id_t       axi_rid_o,
  output data_t     axi_rdata_o,
  output logic      dfi_rst_no,
  output logic      dfi_cke_o,
  output logic      dfi_cs_no,
  output logic      dfi_ras_no,
  output logic      dfi_cas_no,
  output logic      dfi_we_no,
  output logic      dfi_odt_o,
  output bank_t     dfi_bank_o,
  output row_t      dfi_addr_o,
  output logic      dfi_wren_o,
  output mask_t     dfi_mask_o,
  output data_t     dfi_data_o,
  output logic      dfi_rden_o,
  input  logic      dfi_rvld_i,
  input  data_t     dfi_data_i
);

  logic     req_valid;
  logic     req_ready;
  mem_req_t req;
  logic     wr_done;
  logic     wr_issue;
  logic     rd_issue;
  data_t    issue_data;
  mask_t    issue_mask;
  id_t      issue_id;
  logic     wait_load;
  wait_t    wait_count;
  logic     wait_done;
  logic     ref_ack;
  logic     ref_due;
  logic     rd_ret_valid;
  rd_ret_t  rd_ret;
  dfi_cmd_t dfi_cmd;

  // Host channels connect by name
  ddr3_req_ctrl u_req_ctrl (
    .*,
    .req_valid_o    (req_valid),
    .req_ready_i    (req_ready),
    .req_o          (req),
    .wr_done_i      (wr_done),
    .rd_ret_valid_i (rd_ret_valid),
    .rd_ret_i       (rd_ret)
  );

  ddr3_fsm u_fsm (
    .clock        (clock),
    .reset        (reset),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .req_i        (req),
    .wr_done_o    (wr_done),
    .wr_issue_o   (wr_issue),
    .rd_issue_o   (rd_issue),
    .issue_data_o (issue_data),
    .issue_mask_o (issue_mask),
    .issue_id_o   (issue_id),
    .wait_load_o  (wait_load),
    .wait_count_o (wait_count),
    .wait_done_i  (wait_done),
    .ref_ack_o    (ref_ack),
    .ref_due_i    (ref_due),
    .dfi_rst_no   (dfi_rst_no),
    .dfi_cke_o    (dfi_cke_o),
    .dfi_odt_o    (dfi_odt_o),
    .dfi_cmd_o    (dfi_cmd)
  );

  ddr3_timer u_timer (
    .clock        (clock),
    .reset        (reset),
    .wait_load_i  (wait_load),
    .wait_count_i (wait_count),
    .wait_done_o  (wait_done),
    .ref_ack_i    (ref_ack),
    .ref_due_o    (ref_due)
  );

  ddr3_dfi_path u_dfi_path (
    .*,
    .wr_issue_i     (wr_issue),
    .rd_issue_i     (rd_issue),
    .issue_data_i   (issue_data),
    .issue_mask_i   (issue_mask),
    .issue_id_i     (issue_id),
    .rd_ret_valid_o (rd_ret_valid),
    .rd_ret_o       (rd_ret)
  );

  // Command bus out to the DFI pins
  assign dfi_cs_no  = dfi_cmd.cs_n;
  assign dfi_ras_no = dfi_cmd.ras_n;
  assign dfi_cas_no = dfi_cmd.cas_n;
  assign dfi_we_no  = dfi_cmd.we_n;
  assign dfi_bank_o = dfi_cmd.bank;
  assign dfi_addr_o = dfi_cmd.addr;

endmodule

//--- hw/ddr3_dfi_path.sv
`timescale 1ns/1ps
`include "ddr3_lite_defs.svh"

module ddr3_dfi_path import ddr3_bus_pkg::*; (
  input  logic    clock,
  input  logic    reset,
  input  logic    wr_issue_i,
  input  logic    rd_issue_i,
  input  data_t   issue_data_i,
  input  mask_t   issue_mask_i,
  input  id_t     issue_id_i,
  output logic    dfi_wren_o,
  output mask_t   dfi_mask_o,
  output data_t   dfi_data_o,
  output logic    dfi_rden_o,
  input  logic    dfi_rvld_i,
  input  data_t   dfi_data_i,
  output logic    rd_ret_valid_o,
  output rd_ret_t rd_ret_o
);

  logic [`DDR_CWL-1:0] wr_pipe;  // WR strobe, CWL cycles deep
  logic [`DDR_CL-3:0]  rd_pipe;  // RD strobe, CL - 2 cycles deep
  data_t               wr_data;
  mask_t               wr_strb;
  id_t                 rd_id;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_pipe        <= '0;
      rd_pipe        <= '0;
      rd_ret_valid_o <= 1'b0;
    end else begin
      wr_pipe        <= {wr_pipe[`DDR_CWL-2:0], wr_issue_i};
      rd_pipe        <= {rd_pipe[`DDR_CL-4:0], rd_issue_i};
      rd_ret_valid_o <= dfi_rvld_i;
    end
  end

  // Closed page keeps one access in flight, so one stage holds the payload
  always_ff @(posedge clock) begin
    if (wr_issue_i) begin
      wr_data <= issue_data_i;
      wr_strb <= issue_mask_i;
    end
    if (rd_issue_i) rd_id <= issue_id_i;
    if (dfi_rvld_i) begin
      rd_ret_o.id   <= rd_id;
      rd_ret_o.data <= dfi_data_i;
    end
  end

  assign dfi_wren_o = wr_pipe[`DDR_CWL-1];
  assign dfi_data_o = wr_data;
  assign dfi_mask_o = ~wr_strb;  // DM high blocks the byte
  assign dfi_rden_o = rd_pipe[`DDR_CL-3];

endmodule

//--- hw/ddr3_fsm.sv
`timescale 1ns/1ps
`include "ddr3_lite_defs.svh"

module ddr3_fsm import ddr3_cmd_pkg::*, ddr3_bus_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  mem_req_t req_i,
  output logic     wr_done_o,
  output logic     wr_issue_o,
  output logic     rd_issue_o,
  output data_t    issue_data_o,
  output mask_t    issue_mask_o,
  output id_t      issue_id_o,
  output logic     wait_load_o,
  output wait_t    wait_count_o,
  input  logic     wait_done_i,
  output logic     ref_ack_o,
  input  logic     ref_due_i,
  output logic     dfi_rst_no,
  output logic     dfi_cke_o,
  output logic     dfi_odt_o,
  output dfi_cmd_t dfi_cmd_o
);

  // MR0 with WR 6, CL 6 and fixed BL8
  localparam row_t MR0_VALUE = row_t'('h420);

  fsm_state_t state_q;
  fsm_state_t state_d;
  mem_req_t   req_q;
  bank_t      req_bank;
  row_t       req_row;
  col_t       req_col;
  dram_cmd_t  cmd_d;
  bank_t      bank_d;
  row_t       addr_d;
  logic       rst_d;
  logic       cke_d;
  logic       odt_d;
  logic       wr_d;
  logic       rd_d;

  assign {req_bank, req_row, req_col} = req_q.addr;

  always_comb begin
    state_d      = state_q;
    cmd_d        = CMD_NOP;
    bank_d       = '0;
    addr_d       = '0;
    rst_d        = dfi_rst_no;
    cke_d        = dfi_cke_o;
    odt_d        = dfi_odt_o;
    wr_d         = 1'b0;
    rd_d         = 1'b0;
    wait_load_o  = 1'b0;
    wait_count_o = '0;
    ref_ack_o    = 1'b0;
    req_ready_o  = 1'b0;
    case (state_q)
      ST_RESET: begin
        rst_d        = 1'b1;
        wait_load_o  = 1'b1;
        wait_count_o = wait_t'(`DDR_INIT_CYCLES - 2);  // CKE lands on INIT_CYCLES
        state_d      = ST_CKE;
      end
      ST_CKE: if (wait_done_i) begin
        cke_d        = 1'b1;
        wait_load_o  = 1'b1;
        wait_count_o = wait_t'(`DDR_TRP - 1);
        state_d      = ST_MRS;
      end
      ST_MRS: if (wait_done_i) begin
        cmd_d        = CMD_MRS;
        addr_d       = MR0_VALUE;
        wait_load_o  = 1'b1;
        wait_count_o = wait_t'(`DDR_TRP - 1);
        state_d      = ST_IDLE;
      end
      ST_IDLE: begin
        // Requests may be taken early, ACT still waits on the timer
        if (ref_due_i) begin
          state_d = ST_REF;
        end else begin
          req_ready_o = 1'b1;
          if (req_valid_i) state_d = ST_ACT;
        end
      end
      ST_REF: if (wait_done_i) begin
        cmd_d        = CMD_REF;
        ref_ack_o    = 1'b1;
        wait_load_o  = 1'b1;
        wait_count_o = wait_t'(`DDR_TRFC - 1);
        state_d      = ST_IDLE;
      end
      ST_ACT: if (wait_done_i) begin
        cmd_d        = CMD_ACT;
        bank_d       = req_bank;
        addr_d       = req_row;
        wait_load_o  = 1'b1;
        wait_count_o = wait_t'(`DDR_TRCD - 1);
        state_d      = ST_RW;
      end
      ST_RW: if (wait_done_i) begin
        bank_d      = req_bank;
        addr_d      = row_t'(req_col);  // A10 low, no auto precharge
        wait_load_o = 1'b1;
        state_d     = ST_PRE;
        if (req_q.write) begin
          cmd_d        = CMD_WR;
          wr_d         = 1'b1;
          odt_d        = 1'b1;
          wait_count_o = wait_t'(`DDR_CWL + `DDR_TWR);  // WR to PRE is CWL + 1 + tWR
        end else begin
          cmd_d        = CMD_RD;
          rd_d         = 1'b1;
          wait_count_o = wait_t'(`DDR_TRP - 1);
        end
      end
      ST_PRE: if (wait_done_i) begin
        cmd_d        = CMD_PRE;
        bank_d       = req_bank;
        odt_d        = 1'b0;
        wait_load_o  = 1'b1;
        wait_count_o = wait_t'(`DDR_TRP - 1);
        state_d      = ST_IDLE;
      end
      default: state_d = ST_RESET;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q    <= ST_RESET;
      dfi_rst_no <= 1'b0;
      dfi_cke_o  <= 1'b0;
      dfi_odt_o  <= 1'b0;
      wr_issue_o <= 1'b0;
      rd_issue_o <= 1'b0;
      dfi_cmd_o  <= {CMD_NOP, bank_t'(0), row_t'(0)};
    end else begin
      state_q    <= state_d;
      dfi_rst_no <= rst_d;
      dfi_cke_o  <= cke_d;
      dfi_odt_o  <= odt_d;
      wr_issue_o <= wr_d;
      rd_issue_o <= rd_d;
      dfi_cmd_o  <= {cmd_d, bank_d, addr_d};  // One cycle per command
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid_i && req_ready_o) req_q <= req_i;
  end

  assign wr_done_o    = wr_issue_o;  // Write counts as done once WR is out
  assign issue_data_o = req_q.data;
  assign issue_mask_o = req_q.mask;
  assign issue_id_o   = req_q.id;

endmodule

//--- hw/ddr3_timer.sv
`timescale 1ns/1ps
`include "ddr3_lite_defs.svh"

module ddr3_timer import ddr3_cmd_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  wait_load_i,
  input  wait_t wait_count_i,
  output logic  wait_done_o,
  input  logic  ref_ack_i,
  output logic  ref_due_o
);

  localparam int REFI_BITS = $clog2(`DDR_TREFI);
  localparam logic [REFI_BITS-1:0] REFI_LAST = `DDR_TREFI - 1;

  wait_t                wait_cnt;
  logic [REFI_BITS-1:0] refi_cnt;
  logic                 refi_wrap;

  // Done in the cycle the count sits at zero
  assign wait_done_o = (wait_cnt == '0);
  assign refi_wrap   = (refi_cnt == REFI_LAST);

  always_ff @(posedge clock) begin
    if (reset) begin
      wait_cnt <= '0;
    end else if (wait_load_i) begin
      wait_cnt <= wait_count_i;
    end else if (!wait_done_o) begin
      wait_cnt <= wait_cnt - 1'b1;
    end
  end

  // Free-running, independent of the FSM
  always_ff @(posedge clock) begin
    if (reset) begin
      refi_cnt  <= '0;
      ref_due_o <= 1'b0;
    end else begin
      refi_cnt <= refi_wrap ? '0 : refi_cnt + 1'b1;
      if (refi_wrap) ref_due_o <= 1'b1;
      else if (ref_ack_i) ref_due_o <= 1'b0;
    end
  end

  // FSM reloads only after the previous wait has run out
  a_load_when_done: assert property (@(posedge clock) disable iff (reset)
    wait_load_i |-> wait_done_o);

  // A due refresh is served before the next interval ends
  a_no_lost_ref: assert property (@(posedge clock) disable iff (reset)
    refi_wrap |-> !ref_due_o);

endmodule

//--- hw/ddr3_req_ctrl.sv
`timescale 1ns/1ps
`include "ddr3_lite_defs.svh"

module ddr3_req_ctrl import ddr3_bus_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      axi_awvalid_i,
  output logic      axi_awready_o,
  input  mem_addr_t axi_awaddr_i,
  input  id_t       axi_awid_i,
  input  logic      axi_wvalid_i,
  output logic      axi_wready_o,
  input  mask_t     axi_wstrb_i,
  input  data_t     axi_wdata_i,
  output logic      axi_bvalid_o,
  input  logic      axi_bready_i,
  output id_t       axi_bid_o,
  input  logic      axi_arvalid_i,
  output logic      axi_arready_o,
  input  mem_addr_t axi_araddr_i,
  input  id_t       axi_arid_i,
  output logic      axi_rvalid_o,
  input  logic      axi_rready_i,
  output id_t       axi_rid_o,
  output data_t     axi_rdata_o,
  output logic      req_valid_o,
  input  logic      req_ready_i,
  output mem_req_t  req_o,
  input  logic      wr_done_i,
  input  logic      rd_ret_valid_i,
  input  rd_ret_t   rd_ret_i
);

  logic      enable;  // Set once the FSM first comes up idle
  logic      aw_full;
  logic      w_full;
  logic      ar_full;
  mem_addr_t aw_addr;
  id_t       aw_id;
  data_t     w_data;
  mask_t     w_strb;
  mem_addr_t ar_addr;
  id_t       ar_id;
  logic      wr_busy;
  logic      rd_busy;
  logic      wr_elig;
  logic      rd_elig;
  logic      sel_wr;
  logic      wr_first;  // Round-robin priority
  logic      take;
  id_t       wr_id;
  logic      b_full;
  id_t       b_id;
  logic      r_full;
  rd_ret_t   r_slot;

  assign axi_awready_o = enable & ~aw_full;
  assign axi_wready_o  = enable & ~w_full;
  assign axi_arready_o = enable & ~ar_full;

  // A response must always find its slot empty
  assign wr_elig = aw_full & w_full & ~b_full & ~wr_busy;
  assign rd_elig = ar_full & ~r_full & ~rd_busy;
  assign take    = req_valid_o & req_ready_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      enable      <= 1'b0;
      aw_full     <= 1'b0;
      w_full      <= 1'b0;
      ar_full     <= 1'b0;
      req_valid_o <= 1'b0;
      sel_wr      <= 1'b0;
      wr_first    <= 1'b1;
      wr_busy     <= 1'b0;
      rd_busy     <= 1'b0;
      b_full      <= 1'b0;
      r_full      <= 1'b0;
    end else begin
      if (req_ready_i) enable <= 1'b1;

      if (take && sel_wr) begin
        aw_full <= 1'b0;
        w_full  <= 1'b0;
      end else begin
        if (axi_awvalid_i && axi_awready_o) aw_full <= 1'b1;
        if (axi_wvalid_i && axi_wready_o) w_full <= 1'b1;
      end
      if (take && !sel_wr) ar_full <= 1'b0;
      else if (axi_arvalid_i && axi_arready_o) ar_full <= 1'b1;

      // Choice is frozen while the offer is up
      if (take) begin
        req_valid_o <= 1'b0;
        wr_first    <= ~sel_wr;
      end else if (!req_valid_o && (wr_elig || rd_elig)) begin
        req_valid_o <= 1'b1;
        sel_wr      <= wr_elig & (wr_first | ~rd_elig);
      end

      if (take && sel_wr) wr_busy <= 1'b1;
      else if (wr_done_i) wr_busy <= 1'b0;
      if (take && !sel_wr) rd_busy <= 1'b1;
      else if (rd_ret_valid_i) rd_busy <= 1'b0;

      if (wr_done_i) b_full <= 1'b1;
      else if (axi_bready_i) b_full <= 1'b0;
      if (rd_ret_valid_i) r_full <= 1'b1;
      else if (axi_rready_i) r_full <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (axi_awvalid_i && axi_awready_o) begin
      aw_addr <= axi_awaddr_i;
      aw_id   <= axi_awid_i;
    end
    if (axi_wvalid_i && axi_wready_o) begin
      w_data <= axi_wdata_i;
      w_strb <= axi_wstrb_i;
    end
    if (axi_arvalid_i && axi_arready_o) begin
      ar_addr <= axi_araddr_i;
      ar_id   <= axi_arid_i;
    end
    if (take && sel_wr) wr_id <= aw_id;  // ID of the write in flight
    if (wr_done_i) b_id <= wr_id;
    if (rd_ret_valid_i) r_slot <= rd_ret_i;
  end

  always_comb begin
    req_o.write = sel_wr;
    req_o.id    = sel_wr ? aw_id : ar_id;
    req_o.addr  = sel_wr ? aw_addr : ar_addr;
    req_o.data  = w_data;
    req_o.mask  = w_strb;
  end

  assign axi_bvalid_o = b_full;
  assign axi_bid_o    = b_id;
  assign axi_rvalid_o = r_full;
  assign axi_rid_o    = r_slot.id;
  assign axi_rdata_o  = r_slot.data;

endmodule

//--- hw/ddr3_bus_pkg.sv
`include "ddr3_lite_defs.svh"

package ddr3_bus_pkg;

  typedef logic [`DDR_ID_BITS-1:0] id_t;

  // Word address as {bank, row, column}
  typedef logic [`DDR_BANK_BITS+`DDR_ROW_BITS+`DDR_COL_BITS-1:0] mem_addr_t;

  typedef logic [`DDR_DATA_BITS-1:0] data_t;
  typedef logic [`DDR_MASK_BITS-1:0] mask_t;  // Host byte strobes, 1 writes the byte

  // One single-beat access handed to the command FSM
  typedef struct packed {
    logic      write;
    id_t       id;
    mem_addr_t addr;
    data_t     data;
    mask_t     mask;
  } mem_req_t;

  // Read data on its way back to the host
  typedef struct packed {
    id_t   id;
    data_t data;
  } rd_ret_t;

endpackage

//--- hw/ddr3_cmd_pkg.sv
`include "ddr3_lite_defs.svh"

package ddr3_cmd_pkg;

  typedef logic [`DDR_BANK_BITS-1:0] bank_t;
  typedef logic [`DDR_ROW_BITS-1:0] row_t;
  typedef logic [`DDR_COL_BITS-1:0] col_t;

  // Timer load value, sized for the CKE delay
  typedef logic [7:0] wait_t;

  // Bits are {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_NOP = 4'b1111,  // Deselect, chip idle
    CMD_MRS = 4'b0000,
    CMD_REF = 4'b0001,
    CMD_PRE = 4'b0010,
    CMD_ACT = 4'b0011,
    CMD_RD  = 4'b0101,
    CMD_WR  = 4'b0100
  } dram_cmd_t;

  typedef enum logic [2:0] {
    ST_RESET,
    ST_CKE,   // Waiting out the CKE delay
    ST_MRS,
    ST_IDLE,
    ST_REF,
    ST_ACT,
    ST_RW,
    ST_PRE
  } fsm_state_t;

  typedef struct packed {
    logic  cs_n;
    logic  ras_n;
    logic  cas_n;
    logic  we_n;
    bank_t bank;
    row_t  addr;  // Row on ACT, column on RD and WR
  } dfi_cmd_t;

endpackage

//--- include/ddr3_lite_defs.svh
`ifndef DDR3_LITE_DEFS_SVH
`define DDR3_LITE_DEFS_SVH

// Address fields of a word address, bank at the top
`define DDR_BANK_BITS 3
`define DDR_ROW_BITS 13
`define DDR_COL_BITS 10

// Host data word and byte strobes
`define DDR_DATA_BITS 32
`define DDR_MASK_BITS 4
`define DDR_ID_BITS 4

// DRAM timing, all in controller clock cycles
`define DDR_CL 6            // RD to read data
`define DDR_CWL 5           // WR to write data
`define DDR_TRCD 4          // ACT to RD or WR
`define DDR_TRP 4           // PRE to next command
`define DDR_TWR 6           // Write recovery
`define DDR_TRFC 30         // REF to next command
`define DDR_TREFI 780       // Refresh interval
`define DDR_INIT_CYCLES 200 // CKE held low after reset

`endif
